//--- sim.f
+incdir+common
common/csr_types_pkg.sv
common/stats_types_pkg.sv
src/csr_axil_slave.sv
src/csr_counter_ram.sv
stats/stat_accumulators.sv
stats/stat_update_engine.sv
src/stats_csr_top.sv
verification/tb_clock_gen.sv
verification/stats_csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the statistics CSR testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=stats_csr_sim

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f sim.f --top-module stats_csr_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/stats_csr_tb.sv
/*
 * Statistics CSR block testbench
 * Applies a table of AXI4-Lite writes and reads, drives random events
 * against a per-counter reference total and stalls the B and R channels
 */
`timescale 1ns/1ps
`default_nettype none
`include "stats_csr_settings.svh"

module stats_csr_tb;

    localparam int AW       = `CSR_ADDR_WIDTH;
    localparam int DW       = `CSR_DATA_WIDTH;
    localparam int NUM_CNT  = `STATS_NUM_COUNTERS;
    localparam int INTERVAL = `STATS_FLUSH_INTERVAL;
    // Control write and read, three counter sweeps, unmapped rows and mode rows
    localparam int NUM_ROWS = 10 + 3 * NUM_CNT;
    localparam int TIMEOUT_CYCLES = 20 * INTERVAL + 50 * NUM_ROWS;

    // Counter 0 sits at word 8
    localparam int CNT_BASE_ADDR = 8 * 8;

    localparam logic [1:0] OP_WRITE  = 2'd0;
    localparam logic [1:0] OP_READ   = 2'd1;
    localparam logic [1:0] OP_EVENTS = 2'd2;
    localparam logic [1:0] OP_STALL  = 2'd3;

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    localparam logic [DW-1:0] CTRL_A = 64'h0123_4567_89ab_cdef;
    localparam logic [DW-1:0] CTRL_B = 64'hfeed_0000_5a5a_0042;

    // One stimulus row
    typedef struct packed {
        logic [1:0]    op;
        logic [AW-1:0] addr;
        logic [DW-1:0] wdata;
        logic [1:0]    resp;
        logic [DW-1:0] data;
        logic          from_model;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic [AW-1:0]        awaddr;
    logic                 awvalid;
    logic                 awready;
    logic [DW-1:0]        wdata;
    logic [DW/8-1:0]      wstrb;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    logic [AW-1:0]        araddr;
    logic                 arvalid;
    logic                 arready;
    logic [DW-1:0]        rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;
    logic [NUM_CNT-1:0]   events;
    logic [DW-1:0]        ctrl_value;
    logic                 ctrl_valid;

    row_t          rows [NUM_ROWS];
    int            row_count = 0;
    logic [DW-1:0] model_total [NUM_CNT];
    logic [31:0]   lcg_state = 32'habbc;
    logic          stall_on = 1'b0;
    int            errors = 0;
    int            cycles = 0;
    int            ctrl_pulses = 0;
    logic          ctrl_prev = 1'b0;
    logic [DW-1:0] last_ctrl = '0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_i (.clk, .reset);

    stats_csr_top dut_i (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .events, .ctrl_value, .ctrl_valid
    );

    // ==================================================================
    // Helpers
    // ==================================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Ready for B or R, low about three cycles in four while stalling
    function automatic logic ready_pick();
        logic [31:0] rnd;
        if (!stall_on)
            return 1'b1;
        rnd = lcg_next();
        return rnd[31:30] == 2'b00;
    endfunction

    function automatic logic [AW-1:0] counter_addr(input int i);
        return AW'(CNT_BASE_ADDR + 8 * i);
    endfunction

    task automatic check_value(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            errors++;
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_row(input logic [1:0] op, input logic [AW-1:0] addr,
                           input logic [DW-1:0] wd, input logic [1:0] resp,
                           input logic [DW-1:0] data, input logic from_model);
        rows[row_count] = '{op, addr, wd, resp, data, from_model};
        row_count++;
    endtask

    // ==================================================================
    // AXI4-Lite and event drivers
    // ==================================================================

    task automatic write_word(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                              output logic [1:0] resp);
        logic done;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (!(awready && wready))
            @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= ready_pick();
        done = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            if (bvalid && bready)
                done = 1'b1;
            else
                bready <= ready_pick();
        end
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic read_word(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                             output logic [1:0] resp);
        logic          done;
        logic          held;
        logic [DW-1:0] held_data;
        logic [1:0]    held_resp;
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        arvalid <= 1'b0;
        rready  <= ready_pick();
        done = 1'b0;
        held = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            // A stalled response must not move
            if (held)
            begin
                check_value(DW'(rvalid), 1, "rvalid dropped while stalled");
                check_value(rdata, held_data, "rdata changed while stalled");
                check_value(DW'(rresp), DW'(held_resp), "rresp changed while stalled");
            end
            if (rvalid && rready)
            begin
                done = 1'b1;
            end
            else
            begin
                held      = rvalid;
                held_data = rdata;
                held_resp = rresp;
                rready <= ready_pick();
            end
        end
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    // Random events for a number of intervals, then quiet until all are flushed
    task automatic drive_events(input int intervals);
        logic [31:0]        rnd;
        logic [NUM_CNT-1:0] ev;
        repeat (intervals * INTERVAL)
        begin
            rnd = lcg_next();
            ev  = rnd[31 -: NUM_CNT];
            events <= ev;
            for (int i = 0; i < NUM_CNT; i++)
                model_total[i] = model_total[i] + DW'(ev[i]);
            @(posedge clk);
        end
        events <= '0;
        repeat (3 * INTERVAL) @(posedge clk);
    endtask

    // ==================================================================
    // Monitors
    // ==================================================================

    // Control pulse is one cycle wide and rises together with bvalid
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (ctrl_valid)
            begin
                ctrl_pulses++;
                last_ctrl = ctrl_value;
                check_value(DW'(bvalid), 1, "bvalid low during control pulse");
                check_value(DW'(ctrl_prev), 0, "control pulse longer than one cycle");
            end
            ctrl_prev = ctrl_valid;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        logic [1:0]    resp;
        logic [DW-1:0] data;
        logic [DW-1:0] expected;
        int            pulses_before;
        int            idx;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        events  = '0;
        for (int i = 0; i < NUM_CNT; i++)
            model_total[i] = '0;

        // Control register, zeroed counters, error responses
        add_row(OP_WRITE, '0, CTRL_A, OKAY, '0, 1'b0);
        add_row(OP_READ, '0, '0, OKAY, CTRL_A, 1'b0);
        for (int i = 0; i < NUM_CNT; i++)
            add_row(OP_READ, counter_addr(i), '0, OKAY, '0, 1'b0);
        add_row(OP_WRITE, AW'(8'h10), 64'hdead_beef, SLVERR, '0, 1'b0);
        add_row(OP_READ, AW'(8'h10), '0, SLVERR, '0, 1'b0);
        add_row(OP_WRITE, counter_addr(1), 64'h5, SLVERR, '0, 1'b0);
        add_row(OP_READ, AW'(8'hf8), '0, SLVERR, '0, 1'b0);
        // Counting, then the same reads without and with back-pressure
        add_row(OP_EVENTS, '0, 64'd6, OKAY, '0, 1'b0);
        for (int i = 0; i < NUM_CNT; i++)
            add_row(OP_READ, counter_addr(i), '0, OKAY, '0, 1'b1);
        add_row(OP_STALL, '0, 64'd1, OKAY, '0, 1'b0);
        for (int i = 0; i < NUM_CNT; i++)
            add_row(OP_READ, counter_addr(i), '0, OKAY, '0, 1'b1);
        add_row(OP_WRITE, '0, CTRL_B, OKAY, '0, 1'b0);
        add_row(OP_READ, '0, '0, OKAY, CTRL_B, 1'b0);

        @(posedge clk);
        while (reset)
            @(posedge clk);
        check_value(DW'(bvalid), 0, "bvalid after reset");
        check_value(DW'(rvalid), 0, "rvalid after reset");
        check_value(DW'(ctrl_valid), 0, "ctrl_valid after reset");
        check_value(ctrl_value, '0, "ctrl_value after reset");

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            case (rows[r].op)
                OP_WRITE:
                begin
                    pulses_before = ctrl_pulses;
                    write_word(rows[r].addr, rows[r].wdata, resp);
                    check_value(DW'(resp), DW'(rows[r].resp),
                                $sformatf("write response at %h", rows[r].addr));
                    // One more edge so the pulse monitor has settled
                    @(posedge clk);
                    check_value(DW'(ctrl_pulses - pulses_before),
                                (rows[r].resp == OKAY) ? 1 : 0, "control pulse count");
                    if (rows[r].resp == OKAY)
                        check_value(last_ctrl, rows[r].wdata, "control value at pulse");
                end
                OP_READ:
                begin
                    read_word(rows[r].addr, data, resp);
                    if (rows[r].from_model)
                    begin
                        idx = (int'(rows[r].addr) - CNT_BASE_ADDR) / 8;
                        expected = model_total[idx];
                    end
                    else
                    begin
                        expected = rows[r].data;
                    end
                    check_value(DW'(resp), DW'(rows[r].resp),
                                $sformatf("read response at %h", rows[r].addr));
                    check_value(data, expected, $sformatf("read data at %h", rows[r].addr));
                end
                OP_EVENTS:
                begin
                    drive_events(int'(rows[r].wdata));
                end
                default:
                begin
                    stall_on = rows[r].wdata[0];
                end
            endcase
        end

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock and a synchronous active-high reset held for a
 * fixed number of cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops on a rising edge, like any other driven input
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- src/stats_csr_top.sv
/*
 * Statistics and control CSR block
 * AXI4-Lite slave, counter memory, event accumulators and update engine
 */
`timescale 1ns/1ps
`default_nettype none
`include "stats_csr_settings.svh"

module stats_csr_top
    import csr_types_pkg::*;
    import stats_types_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire [`CSR_ADDR_WIDTH-1:0]     awaddr,
    input  wire                           awvalid,
    output logic                          awready,
    input  wire [`CSR_DATA_WIDTH-1:0]     wdata,
    input  wire [`CSR_DATA_WIDTH/8-1:0]   wstrb,
    input  wire                           wvalid,
    output logic                          wready,
    output axil_resp_e                    bresp,
    output logic                          bvalid,
    input  wire                           bready,
    input  wire [`CSR_ADDR_WIDTH-1:0]     araddr,
    input  wire                           arvalid,
    output logic                          arready,
    output logic [`CSR_DATA_WIDTH-1:0]    rdata,
    output axil_resp_e                    rresp,
    output logic                          rvalid,
    input  wire                           rready,
    input  wire [`STATS_NUM_COUNTERS-1:0] events,
    output logic [`CSR_DATA_WIDTH-1:0]    ctrl_value,
    output logic                          ctrl_valid
);

    logic                       mem_ready;
    logic                       host_rd_en;
    counter_idx_t               host_rd_idx;
    logic                       eng_rd_en;
    counter_idx_t               eng_rd_idx;
    logic                       ram_rd_en;
    counter_idx_t               ram_rd_idx;
    logic [`CSR_DATA_WIDTH-1:0] rd_data;
    logic                       rd_data_valid;
    logic                       wr_en;
    counter_idx_t               wr_idx;
    logic [`CSR_DATA_WIDTH-1:0] wr_data;
    logic                       flush_valid;
    accum_vec_t                 flush_counts;
    logic                       upd_ready;

    // Read port mux, host first
    assign ram_rd_en  = host_rd_en || eng_rd_en;
    assign ram_rd_idx = host_rd_en ? host_rd_idx : eng_rd_idx;

    csr_axil_slave slave_i (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .ctrl_value, .ctrl_valid,
        .mem_ready, .host_rd_en, .host_rd_idx, .rd_data, .rd_data_valid
    );

    csr_counter_ram ram_i (
        .clk, .reset,
        .rd_en(ram_rd_en), .rd_idx(ram_rd_idx), .rd_data, .rd_data_valid,
        .wr_en, .wr_idx, .wr_data, .mem_ready
    );

    stat_accumulators accum_i (
        .clk, .reset, .events, .upd_ready, .flush_valid, .flush_counts
    );

    stat_update_engine engine_i (
        .clk, .reset, .flush_valid, .flush_counts, .upd_ready,
        .host_rd_en, .mem_ready, .rd_en(eng_rd_en), .rd_idx(eng_rd_idx),
        .rd_data, .rd_data_valid, .wr_en, .wr_idx, .wr_data
    );

endmodule

`default_nettype wire

//--- stats/stat_update_engine.sv
/*
 * Counter update engine
 * Latches a handed-over accumulator vector and, entry by entry, reads
 * the counter, adds the accumulator and writes the sum back. Host reads
 * take the memory read port first
 */
`timescale 1ns/1ps
`default_nettype none
`include "stats_csr_settings.svh"

module stat_update_engine
    import csr_types_pkg::*;
    import stats_types_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        flush_valid,
    input  wire accum_vec_t            flush_counts,
    output logic                       upd_ready,
    input  wire                        host_rd_en,
    input  wire                        mem_ready,
    output logic                       rd_en,
    output counter_idx_t               rd_idx,
    input  wire [`CSR_DATA_WIDTH-1:0]  rd_data,
    input  wire                        rd_data_valid,
    output logic                       wr_en,
    output counter_idx_t               wr_idx,
    output logic [`CSR_DATA_WIDTH-1:0] wr_data
);

    localparam int DW = `CSR_DATA_WIDTH;
    localparam counter_idx_t LAST_IDX = counter_idx_t'(`STATS_NUM_COUNTERS - 1);

    stat_upd_state_e state;
    accum_vec_t      counts_q;
    counter_idx_t    idx;
    logic            wait_cnt;
    logic [DW-1:0]   sum;

    // Yield to a host read in the same cycle
    assign rd_en   = (state == UPD_READ) && !host_rd_en && mem_ready;
    assign rd_idx  = idx;
    assign wr_en   = (state == UPD_WRITE);
    assign wr_idx  = idx;
    assign wr_data = sum;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= UPD_IDLE;
            upd_ready <= 1'b1;
            idx       <= '0;
            wait_cnt  <= 1'b0;
        end
        else
        begin
            case (state)
                UPD_IDLE:
                begin
                    if (flush_valid)
                    begin
                        state     <= UPD_READ;
                        upd_ready <= 1'b0;
                        idx       <= '0;
                    end
                end
                UPD_READ:
                begin
                    if (rd_en)
                    begin
                        state    <= UPD_WAIT;
                        wait_cnt <= 1'b0;
                    end
                end
                UPD_WAIT:
                begin
                    // Our data comes on the second wait cycle and earlier host data is skipped
                    wait_cnt <= 1'b1;
                    if (wait_cnt && rd_data_valid)
                        state <= UPD_WRITE;
                end
                default:
                begin
                    // After the write-back go to the next entry or back to idle
                    if (idx == LAST_IDX)
                    begin
                        state     <= UPD_IDLE;
                        upd_ready <= 1'b1;
                    end
                    else
                    begin
                        state <= UPD_READ;
                        idx   <= idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // Latched vector and the sum for the write-back
    always_ff @(posedge clk)
    begin
        if (state == UPD_IDLE && flush_valid)
            counts_q <= flush_counts;
        if (state == UPD_WAIT && wait_cnt && rd_data_valid)
            sum <= rd_data + DW'(counts_q[idx]);
    end

    // Memory must return our read exactly on the second wait cycle
    assert property (@(posedge clk) disable iff (reset)
        (state == UPD_WAIT) && wait_cnt |-> rd_data_valid);

endmodule

`default_nettype wire

//--- stats/stat_accumulators.sv
/*
 * Event accumulators
 * Registers the event inputs, adds them into narrow accumulators and
 * offers the accumulator vector to the update engine at a fixed interval
 */
`timescale 1ns/1ps
`default_nettype none
`include "stats_csr_settings.svh"

module stat_accumulators
    import stats_types_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire [`STATS_NUM_COUNTERS-1:0] events,
    input  wire                           upd_ready,
    output logic                          flush_valid,
    output accum_vec_t                    flush_counts
);

    localparam int AW      = `STATS_ACCUM_WIDTH;
    localparam int TIMER_W = $clog2(`STATS_FLUSH_INTERVAL);

    logic [`STATS_NUM_COUNTERS-1:0] events_q;
    logic [TIMER_W-1:0]             timer;
    logic                           handover;

    assign handover = flush_valid && upd_ready;

    // ==================================================================
    // Flush interval timer
    // ==================================================================

    // Timer holds while a flush waits, so the request repeats each cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            timer       <= '0;
            flush_valid <= 1'b0;
        end
        else if (!flush_valid)
        begin
            if (timer == TIMER_W'(`STATS_FLUSH_INTERVAL - 1))
            begin
                flush_valid <= 1'b1;
                timer       <= '0;
            end
            else
            begin
                timer <= timer + 1'b1;
            end
        end
        else if (upd_ready)
        begin
            flush_valid <= 1'b0;
        end
    end

    // ==================================================================
    // Accumulators
    // ==================================================================

    // On hand-over restart from this cycle's events so none is lost
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            events_q     <= '0;
            flush_counts <= '0;
        end
        else
        begin
            events_q <= events;
            for (int i = 0; i < `STATS_NUM_COUNTERS; i++)
            begin
                flush_counts[i] <= (handover ? '0 : flush_counts[i]) + AW'(events_q[i]);
            end
        end
    end

    // A full accumulator may only take an event when it is handed over
    for (genvar g = 0; g < `STATS_NUM_COUNTERS; g++)
    begin : g_wrap_chk
        assert property (@(posedge clk) disable iff (reset)
            (&flush_counts[g]) && events_q[g] |-> handover);
    end

endmodule

`default_nettype wire

//--- src/csr_counter_ram.sv
/*
 * Counter memory
 * 64-bit entries behind a two-stage registered read, one write port,
 * zeroed by a sweep after reset before accesses are accepted
 */
`timescale 1ns/1ps
`default_nettype none
`include "stats_csr_settings.svh"

module csr_counter_ram
    import csr_types_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        rd_en,
    input  wire counter_idx_t          rd_idx,
    output logic [`CSR_DATA_WIDTH-1:0] rd_data,
    output logic                       rd_data_valid,
    input  wire                        wr_en,
    input  wire counter_idx_t          wr_idx,
    input  wire [`CSR_DATA_WIDTH-1:0]  wr_data,
    output logic                       mem_ready
);

    localparam counter_idx_t LAST_IDX = counter_idx_t'(`STATS_NUM_COUNTERS - 1);

    logic [`CSR_DATA_WIDTH-1:0] mem [`STATS_NUM_COUNTERS];
    logic [`CSR_DATA_WIDTH-1:0] rd_stage;
    logic                       rd_stage_valid;
    counter_idx_t               init_idx;

    // Zeroing sweep, one entry per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx  <= '0;
            mem_ready <= 1'b0;
        end
        else if (!mem_ready)
        begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == LAST_IDX)
                mem_ready <= 1'b1;
        end
    end

    // Write port shared by sweep and engine
    always_ff @(posedge clk)
    begin
        if (!mem_ready)
            mem[init_idx] <= '0;
        else if (wr_en)
            mem[wr_idx] <= wr_data;
    end

    // Two read stages, several reads may be in flight
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_stage <= mem[rd_idx];
        if (rd_stage_valid)
            rd_data <= rd_stage;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_stage_valid <= 1'b0;
            rd_data_valid  <= 1'b0;
        end
        else
        begin
            rd_stage_valid <= rd_en;
            rd_data_valid  <= rd_stage_valid;
        end
    end

    // Clients must wait for the sweep
    assert property (@(posedge clk) disable iff (reset)
        !mem_ready |-> !rd_en && !wr_en);

endmodule

`default_nettype wire

//--- src/csr_axil_slave.sv
/*
 * AXI4-Lite CSR slave
 * Decodes the register map, holds the control register and turns
 * counter word reads into reads of the counter memory
 */
`timescale 1ns/1ps
`default_nettype none
`include "stats_csr_settings.svh"

module csr_axil_slave
    import csr_types_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`CSR_ADDR_WIDTH-1:0]  awaddr,
    input  wire                        awvalid,
    output logic                       awready,
    input  wire [`CSR_DATA_WIDTH-1:0]  wdata,
    input  wire [`CSR_DATA_WIDTH/8-1:0] wstrb,
    input  wire                        wvalid,
    output logic                       wready,
    output axil_resp_e                 bresp,
    output logic                       bvalid,
    input  wire                        bready,
    input  wire [`CSR_ADDR_WIDTH-1:0]  araddr,
    input  wire                        arvalid,
    output logic                       arready,
    output logic [`CSR_DATA_WIDTH-1:0] rdata,
    output axil_resp_e                 rresp,
    output logic                       rvalid,
    input  wire                        rready,
    output logic [`CSR_DATA_WIDTH-1:0] ctrl_value,
    output logic                       ctrl_valid,
    input  wire                        mem_ready,
    output logic                       host_rd_en,
    output counter_idx_t               host_rd_idx,
    input  wire [`CSR_DATA_WIDTH-1:0]  rd_data,
    input  wire                        rd_data_valid
);

    // One past the last counter word
    localparam csr_word_t CNT_END_WORD =
        CSR_COUNTER_BASE_WORD + csr_word_t'(`STATS_NUM_COUNTERS);

    csr_word_t    aw_word;
    csr_word_t    ar_word;
    logic         wr_accept;
    logic         ar_accept;
    logic         ar_is_counter;
    logic         cnt_rd_busy;
    counter_idx_t cnt_rd_idx;
    logic [1:0]   host_pipe;
    logic         rd_capture;

    // Byte address down to 64-bit word
    assign aw_word = awaddr[`CSR_ADDR_WIDTH-1:3];
    assign ar_word = araddr[`CSR_ADDR_WIDTH-1:3];

    // ==================================================================
    // Write channel
    // ==================================================================

    // AW and W taken together, held off while a B response waits
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bvalid     <= 1'b0;
            bresp      <= RESP_OKAY;
            ctrl_valid <= 1'b0;
            ctrl_value <= '0;
        end
        else
        begin
            // Control pulse lasts one cycle
            ctrl_valid <= 1'b0;
            if (wr_accept)
            begin
                bvalid <= 1'b1;
                // Only the control word is writable
                if (aw_word == CSR_CTRL_WORD)
                begin
                    bresp      <= RESP_OKAY;
                    ctrl_value <= wdata;
                    ctrl_valid <= 1'b1;
                end
                else
                begin
                    bresp <= RESP_SLVERR;
                end
            end
            else if (bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Read channel
    // ==================================================================

    assign ar_is_counter = (ar_word >= CSR_COUNTER_BASE_WORD) && (ar_word < CNT_END_WORD);
    assign arready       = !rvalid && !cnt_rd_busy;
    assign ar_accept     = arvalid && arready;

    // Issue once the memory is swept and our own read has drained
    assign host_rd_en  = cnt_rd_busy && mem_ready && (host_pipe == 2'b00);
    assign host_rd_idx = cnt_rd_idx;
    // Data for our read arrives two cycles after issue
    assign rd_capture  = host_pipe[1] && rd_data_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rvalid      <= 1'b0;
            cnt_rd_busy <= 1'b0;
            host_pipe   <= 2'b00;
        end
        else
        begin
            host_pipe <= {host_pipe[0], host_rd_en};
            if (ar_accept)
            begin
                // Counter words wait for memory, the rest answer now
                if (ar_is_counter)
                    cnt_rd_busy <= 1'b1;
                else
                    rvalid <= 1'b1;
            end
            else if (rd_capture)
            begin
                rvalid      <= 1'b1;
                cnt_rd_busy <= 1'b0;
            end
            else if (rready)
            begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk)
    begin
        if (ar_accept)
        begin
            cnt_rd_idx <= counter_idx_t'(ar_word - CSR_COUNTER_BASE_WORD);
            if (ar_word == CSR_CTRL_WORD)
            begin
                rdata <= ctrl_value;
                rresp <= RESP_OKAY;
            end
            else if (!ar_is_counter)
            begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
        else if (rd_capture)
        begin
            rdata <= rd_data;
            rresp <= RESP_OKAY;
        end
    end

    // Held R response must not change until taken
    assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> $stable(rdata) && $stable(rresp));

    // Only full-word writes are supported
    assert property (@(posedge clk) disable iff (reset)
        wr_accept |-> (&wstrb));

endmodule

`default_nettype wire

//--- common/stats_types_pkg.sv
/*
 * Statistics path types
 * Update engine states and the accumulator vector passed at hand-over
 */
`default_nettype none
`include "stats_csr_settings.svh"

package stats_types_pkg;

    // Update engine, one read-add-writeback per entry
    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_READ,
        UPD_WAIT,
        UPD_WRITE
    } stat_upd_state_e;

    // All accumulators, index 0 is counter 0
    typedef logic [`STATS_NUM_COUNTERS-1:0][`STATS_ACCUM_WIDTH-1:0] accum_vec_t;

endpackage

`default_nettype wire

//--- common/csr_types_pkg.sv
/*
 * CSR address map types
 * Word indices, counter indices and AXI4-Lite response codes
 */
`default_nettype none
`include "stats_csr_settings.svh"

package csr_types_pkg;

    // Index of a 64-bit word in the CSR space
    typedef logic [`CSR_ADDR_WIDTH-4:0] csr_word_t;

    // Entry index into the counter memory
    typedef logic [$clog2(`STATS_NUM_COUNTERS)-1:0] counter_idx_t;

    // Register map, in 64-bit words
    localparam csr_word_t CSR_CTRL_WORD = csr_word_t'(0);
    localparam csr_word_t CSR_COUNTER_BASE_WORD = csr_word_t'(8);

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

endpackage

`default_nettype wire

//--- common/stats_csr_settings.svh
/*
 * Statistics CSR block build settings
 * Sizes of the counter bank, the accumulators and the AXI4-Lite port
 */
`ifndef STATS_CSR_SETTINGS_SVH
`define STATS_CSR_SETTINGS_SVH

// Event inputs, one counter entry per event
`define STATS_NUM_COUNTERS 4

// Narrow per-event accumulator width
`define STATS_ACCUM_WIDTH 8

// Cycles between accumulator hand-overs, kept below 2**STATS_ACCUM_WIDTH
`define STATS_FLUSH_INTERVAL 64

// AXI4-Lite byte address and data widths
`define CSR_ADDR_WIDTH 8
`define CSR_DATA_WIDTH 64

`endif
